// File: rtl/cdc_macros.svh
/* Depths and field widths for the two-channel crossing merger.
   Included by the packages and by every module that sizes storage. */
`ifndef CDC_MACROS_SVH
`define CDC_MACROS_SVH

// Dual-clock core, 32 entries
`define CDC_CORE_AW 5

// Read-side prefetch register FIFO, 4 entries
`define CDC_PREFETCH_AW 2

// Payload fields
`define CDC_SAMPLE_W 24
`define CDC_CMD_OP_W 4
`define CDC_CMD_ARG_W 12

// Room for core plus prefetch plus one word in transit
`define CDC_LEVEL_W (`CDC_CORE_AW + 2)

`endif

// File: rtl/cdc_pkg.sv
/* FIFO status types, shared by the crossing FIFOs and the top level. */
`include "cdc_macros.svh"

package cdc_pkg;

  ////////////////////////////////////////
  // Fill levels
  ////////////////////////////////////////

  // Count of stored words
  typedef logic [`CDC_LEVEL_W-1:0] fill_level_t;

  // Write side, current and peak-held fill level
  typedef struct packed {
    fill_level_t fill_level;
    fill_level_t max_fill_level;
  } wr_status_t;

  // Read side, words reachable by read strobes
  typedef struct packed {
    fill_level_t fill_level;
  } rd_status_t;

endpackage

// File: rtl/stream_pkg.sv
/* Payload types of the audio and command streams and the tagged word
   that the merger hands out on the read side. */
`include "cdc_macros.svh"

package stream_pkg;

  ////////////////////////////////////////
  // Channel payloads
  ////////////////////////////////////////

  // Audio sample with its left/right flag
  typedef struct packed {
    logic [`CDC_SAMPLE_W-1:0] data;
    logic                     lr;
  } sample_t;

  // Control command
  typedef struct packed {
    logic [`CDC_CMD_OP_W-1:0]  opcode;
    logic [`CDC_CMD_ARG_W-1:0] arg;
  } cmd_t;

  ////////////////////////////////////////
  // Merged output
  ////////////////////////////////////////

  typedef enum logic {
    SRC_SAMPLE = 1'b0,
    SRC_CMD    = 1'b1
  } src_e;

  // Sample fills the payload, command sits in the low bits
  typedef struct packed {
    src_e                   src;
    logic [`CDC_SAMPLE_W:0] payload;
  } merged_t;

endpackage

// File: rtl/gray_sync.sv
/* Carries a binary pointer into another clock domain as registered Gray
   code through two flops, and hands back the Gray value and its decode. */
module gray_sync #(
  parameter int WIDTH = 6
) (
  input  logic             src_clk,
  input  logic             src_rst_n,
  input  logic             dst_clk,
  input  logic             dst_rst_n,
  input  logic [WIDTH-1:0] bin_ptr,
  output logic [WIDTH-1:0] gray_sync_ptr,
  output logic [WIDTH-1:0] bin_sync_ptr
);

  logic [WIDTH-1:0] gray_src;
  logic [WIDTH-1:0] gray_meta;

  // Gray form registered in the source clock, no glitches cross
  always_ff @(posedge src_clk or negedge src_rst_n) begin
    if (!src_rst_n) begin
      gray_src <= '0;
    end else begin
      gray_src <= bin_ptr ^ (bin_ptr >> 1);
    end
  end

  // Two-flop synchronizer in the destination clock
  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      gray_meta     <= '0;
      gray_sync_ptr <= '0;
    end else begin
      gray_meta     <= gray_src;
      gray_sync_ptr <= gray_meta;
    end
  end

  // Gray to binary, each bit is the XOR of all bits at and above it
  always_comb begin
    for (int i = 0; i < WIDTH; i++) begin
      bin_sync_ptr[i] = ^(gray_sync_ptr >> i);
    end
  end

endmodule

// File: rtl/afifo_core.sv
/* Dual-clock storage of the crossing FIFO with Gray pointer exchange.
   Read data is registered, so a word lands one clk_rp cycle after rd_en. */
`include "cdc_macros.svh"

module afifo_core #(
  parameter type payload_t = logic
) (
  input  logic               clk_wp,
  input  logic               rst_wp_n,
  input  logic               clk_rp,
  input  logic               rst_rp_n,
  input  logic               wr_en,
  input  payload_t           wr_data,
  output logic               full,
  input  logic               rd_en,
  output payload_t           rd_data,
  output logic               empty,
  output cdc_pkg::wr_status_t wr_status,
  output cdc_pkg::rd_status_t rd_status
);

  localparam int AW    = `CDC_CORE_AW;
  localparam int DEPTH = 1 << AW;

  payload_t mem [DEPTH];

  // Pointers carry one wrap bit above the address
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic [AW:0] wr_gray;
  logic [AW:0] rd_gray;
  logic [AW:0] rd_gray_wsync;
  logic [AW:0] rd_bin_wsync;
  logic [AW:0] wr_gray_rsync;
  logic [AW:0] wr_bin_rsync;
  // Pointer differences at pointer width
  logic [AW:0] wr_diff;
  logic [AW:0] rd_diff;

  cdc_pkg::fill_level_t wr_level;
  cdc_pkg::fill_level_t wr_max_level;

  ////////////////////////////////////////
  // Write domain
  ////////////////////////////////////////

  assign wr_gray = wr_ptr ^ (wr_ptr >> 1);

  // Full when write is one lap ahead of the synced read pointer
  assign full = (wr_gray == {~rd_gray_wsync[AW:AW-1], rd_gray_wsync[AW-2:0]});

  always_ff @(posedge clk_wp or negedge rst_wp_n) begin
    if (!rst_wp_n) begin
      wr_ptr <= '0;
    end else if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk_wp) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= wr_data;
    end
  end

  // Level as seen from the write side where the read pointer lags by the sync
  // Taken at pointer width so a pointer wrap drops out
  assign wr_diff  = wr_ptr - rd_bin_wsync;
  assign wr_level = cdc_pkg::fill_level_t'(wr_diff);

  always_ff @(posedge clk_wp or negedge rst_wp_n) begin
    if (!rst_wp_n) begin
      wr_max_level <= '0;
    end else if (wr_level > wr_max_level) begin
      wr_max_level <= wr_level;
    end
  end

  assign wr_status = '{fill_level: wr_level, max_fill_level: wr_max_level};

  ////////////////////////////////////////
  // Read domain
  ////////////////////////////////////////

  assign rd_gray = rd_ptr ^ (rd_ptr >> 1);
  assign empty   = (rd_gray == wr_gray_rsync);

  always_ff @(posedge clk_rp or negedge rst_rp_n) begin
    if (!rst_rp_n) begin
      rd_ptr <= '0;
    end else if (rd_en) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk_rp) begin
    if (rd_en) begin
      rd_data <= mem[rd_ptr[AW-1:0]];
    end
  end

  assign rd_diff              = wr_bin_rsync - rd_ptr;
  assign rd_status.fill_level = cdc_pkg::fill_level_t'(rd_diff);

  // One synchronizer per pointer direction
  gray_sync #(.WIDTH(AW + 1)) u_wr_sync (
    .src_clk       (clk_wp),
    .src_rst_n     (rst_wp_n),
    .dst_clk       (clk_rp),
    .dst_rst_n     (rst_rp_n),
    .bin_ptr       (wr_ptr),
    .gray_sync_ptr (wr_gray_rsync),
    .bin_sync_ptr  (wr_bin_rsync)
  );

  gray_sync #(.WIDTH(AW + 1)) u_rd_sync (
    .src_clk       (clk_rp),
    .src_rst_n     (rst_rp_n),
    .dst_clk       (clk_wp),
    .dst_rst_n     (rst_wp_n),
    .bin_ptr       (rd_ptr),
    .gray_sync_ptr (rd_gray_wsync),
    .bin_sync_ptr  (rd_bin_wsync)
  );

endmodule

// File: rtl/prefetch_fifo.sv
/* Small register FIFO in the read clock that buffers words pulled from the
   dual-clock core. Head word is visible on pop_data without a cycle delay. */
`include "cdc_macros.svh"

module prefetch_fifo #(
  parameter type payload_t = logic
) (
  input  logic                      clk_rp,
  input  logic                      rst_rp_n,
  input  logic                      push,
  input  payload_t                  push_data,
  input  logic                      pop,
  output payload_t                  pop_data,
  output logic                      empty,
  output logic [`CDC_PREFETCH_AW:0] fill_level
);

  localparam int AW    = `CDC_PREFETCH_AW;
  localparam int DEPTH = 1 << AW;

  payload_t regs [DEPTH];

  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;

  ////////////////////////////////////////
  // Pointers
  ////////////////////////////////////////

  // No full check here, the caller watches fill_level
  always_ff @(posedge clk_rp or negedge rst_rp_n) begin
    if (!rst_rp_n) begin
      wr_ptr <= '0;
    end else if (push) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk_rp or negedge rst_rp_n) begin
    if (!rst_rp_n) begin
      rd_ptr <= '0;
    end else if (pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  always_ff @(posedge clk_rp) begin
    if (push) begin
      regs[wr_ptr[AW-1:0]] <= push_data;
    end
  end

  // Head word straight out of the register file
  assign pop_data = regs[rd_ptr[AW-1:0]];

  // Wrap bit keeps full and empty apart
  assign fill_level = wr_ptr - rd_ptr;
  assign empty      = (wr_ptr == rd_ptr);

endmodule

// File: rtl/afifo.sv
/* Crossing FIFO for one payload type, core in two clocks plus a read-side
   prefetch. Read with read_en while not empty, data_out comes with valid. */
`include "cdc_macros.svh"

module afifo #(
  parameter type payload_t = logic
) (
  input  logic                clk_wp,
  input  logic                rst_wp_n,
  input  logic                clk_rp,
  input  logic                rst_rp_n,
  input  logic                write_en,
  input  payload_t            data_in,
  output logic                full,
  input  logic                read_en,
  output payload_t            data_out,
  output logic                valid,
  output logic                empty,
  output cdc_pkg::wr_status_t wr_status,
  output cdc_pkg::rd_status_t rd_status
);

  localparam int PF_DEPTH = 1 << `CDC_PREFETCH_AW;

  logic                      wr_accept;
  logic                      rd_accept;
  logic                      core_empty;
  logic                      core_pull;
  // Word read from the core, pushed into the prefetch next cycle
  logic                      core_pull_d;
  payload_t                  core_data;
  payload_t                  pf_data;
  logic [`CDC_PREFETCH_AW:0] pf_level;
  cdc_pkg::rd_status_t       core_rd_status;

  // Requests against full or empty are dropped
  assign wr_accept = write_en && !full;
  assign rd_accept = read_en && !empty;

  ////////////////////////////////////////
  // Core to prefetch transfer
  ////////////////////////////////////////

  // Pull while the prefetch has room, counting the word in transit
  assign core_pull = !core_empty &&
    ((cdc_pkg::fill_level_t'(pf_level) + cdc_pkg::fill_level_t'(core_pull_d)) < PF_DEPTH);

  always_ff @(posedge clk_rp or negedge rst_rp_n) begin
    if (!rst_rp_n) begin
      core_pull_d <= 1'b0;
      valid       <= 1'b0;
    end else begin
      core_pull_d <= core_pull;
      valid       <= rd_accept;
    end
  end

  // Output word, valid marks it
  always_ff @(posedge clk_rp) begin
    if (rd_accept) begin
      data_out <= pf_data;
    end
  end

  // Everything reachable by read strobes, nothing while empty
  always_comb begin
    if (empty) begin
      rd_status.fill_level = '0;
    end else begin
      rd_status.fill_level = core_rd_status.fill_level
        + cdc_pkg::fill_level_t'(pf_level)
        + cdc_pkg::fill_level_t'(core_pull_d);
    end
  end

  afifo_core #(.payload_t(payload_t)) u_core (
    .clk_wp    (clk_wp),
    .rst_wp_n  (rst_wp_n),
    .clk_rp    (clk_rp),
    .rst_rp_n  (rst_rp_n),
    .wr_en     (wr_accept),
    .wr_data   (data_in),
    .full      (full),
    .rd_en     (core_pull),
    .rd_data   (core_data),
    .empty     (core_empty),
    .wr_status (wr_status),
    .rd_status (core_rd_status)
  );

  prefetch_fifo #(.payload_t(payload_t)) u_prefetch (
    .clk_rp     (clk_rp),
    .rst_rp_n   (rst_rp_n),
    .push       (core_pull_d),
    .push_data  (core_data),
    .pop        (rd_accept),
    .pop_data   (pf_data),
    .empty      (empty),
    .fill_level (pf_level)
  );

endmodule

// File: rtl/stream_merge.sv
/* Round-robin merger of the sample and command FIFOs in the read clock.
   One read_en issues one channel read, the tagged word follows on out_valid. */
module stream_merge (
  input  logic                clk_rp,
  input  logic                rst_rp_n,
  input  logic                read_en,
  input  logic                sample_empty,
  input  logic                cmd_empty,
  output logic                sample_rd_en,
  output logic                cmd_rd_en,
  input  stream_pkg::sample_t sample_data,
  input  logic                sample_valid,
  input  stream_pkg::cmd_t    cmd_data,
  input  logic                cmd_valid,
  output stream_pkg::merged_t out_data,
  output logic                out_valid,
  output logic                empty
);

  stream_pkg::src_e    last_src;
  stream_pkg::merged_t next_word;

  ////////////////////////////////////////
  // Channel select
  ////////////////////////////////////////

  // Lone non-empty channel wins, otherwise the one not served last
  assign sample_rd_en = read_en && !sample_empty &&
                        (cmd_empty || last_src == stream_pkg::SRC_CMD);
  assign cmd_rd_en    = read_en && !cmd_empty &&
                        (sample_empty || last_src == stream_pkg::SRC_SAMPLE);

  assign empty = sample_empty && cmd_empty;

  // Starts as command so the first pick is a sample
  always_ff @(posedge clk_rp or negedge rst_rp_n) begin
    if (!rst_rp_n) begin
      last_src <= stream_pkg::SRC_CMD;
    end else if (sample_rd_en) begin
      last_src <= stream_pkg::SRC_SAMPLE;
    end else if (cmd_rd_en) begin
      last_src <= stream_pkg::SRC_CMD;
    end
  end

  ////////////////////////////////////////
  // Tag and register
  ////////////////////////////////////////

  // At most one valid per cycle since reads are exclusive
  always_comb begin
    next_word.src     = stream_pkg::SRC_SAMPLE;
    next_word.payload = sample_data;
    if (cmd_valid) begin
      next_word.src     = stream_pkg::SRC_CMD;
      next_word.payload = '0;
      next_word.payload[$bits(stream_pkg::cmd_t)-1:0] = cmd_data;
    end
  end

  always_ff @(posedge clk_rp or negedge rst_rp_n) begin
    if (!rst_rp_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= sample_valid || cmd_valid;
    end
  end

  always_ff @(posedge clk_rp) begin
    if (sample_valid || cmd_valid) begin
      out_data <= next_word;
    end
  end

endmodule

// File: rtl/cdc_merge_top.sv
/* Two-channel crossing merger, samples and commands in clk_wp, one tagged
   stream out in clk_rp. */
module cdc_merge_top (
  input  logic                clk_wp,
  input  logic                rst_wp_n,
  input  logic                clk_rp,
  input  logic                rst_rp_n,
  input  logic                sample_write_en,
  input  stream_pkg::sample_t sample_data,
  output logic                sample_full,
  input  logic                cmd_write_en,
  input  stream_pkg::cmd_t    cmd_data,
  output logic                cmd_full,
  input  logic                read_en,
  output stream_pkg::merged_t out_data,
  output logic                out_valid,
  output logic                empty,
  output cdc_pkg::wr_status_t sample_wr_status,
  output cdc_pkg::wr_status_t cmd_wr_status,
  output cdc_pkg::rd_status_t sample_rd_status,
  output cdc_pkg::rd_status_t cmd_rd_status
);

  logic                sample_rd_en;
  logic                sample_empty;
  logic                sample_valid;
  stream_pkg::sample_t sample_rd_data;
  logic                cmd_rd_en;
  logic                cmd_empty;
  logic                cmd_valid;
  stream_pkg::cmd_t    cmd_rd_data;

  // Audio channel crossing
  afifo #(.payload_t(stream_pkg::sample_t)) u_sample_fifo (
    .clk_wp (clk_wp), .rst_wp_n (rst_wp_n), .clk_rp (clk_rp), .rst_rp_n (rst_rp_n),
    .write_en  (sample_write_en),
    .data_in   (sample_data),
    .full      (sample_full),
    .read_en   (sample_rd_en),
    .data_out  (sample_rd_data),
    .valid     (sample_valid),
    .empty     (sample_empty),
    .wr_status (sample_wr_status),
    .rd_status (sample_rd_status)
  );

  // Command channel crossing
  afifo #(.payload_t(stream_pkg::cmd_t)) u_cmd_fifo (
    .clk_wp (clk_wp), .rst_wp_n (rst_wp_n), .clk_rp (clk_rp), .rst_rp_n (rst_rp_n),
    .write_en  (cmd_write_en),
    .data_in   (cmd_data),
    .full      (cmd_full),
    .read_en   (cmd_rd_en),
    .data_out  (cmd_rd_data),
    .valid     (cmd_valid),
    .empty     (cmd_empty),
    .wr_status (cmd_wr_status),
    .rd_status (cmd_rd_status)
  );

  stream_merge u_merge (
    .clk_rp       (clk_rp),
    .rst_rp_n     (rst_rp_n),
    .read_en      (read_en),
    .sample_empty (sample_empty),
    .cmd_empty    (cmd_empty),
    .sample_rd_en (sample_rd_en),
    .cmd_rd_en    (cmd_rd_en),
    .sample_data  (sample_rd_data),
    .sample_valid (sample_valid),
    .cmd_data     (cmd_rd_data),
    .cmd_valid    (cmd_valid),
    .out_data     (out_data),
    .out_valid    (out_valid),
    .empty        (empty)
  );

endmodule

// File: testbench/tb_checks.svh
/* Compare tasks for the merger testbench, typed to the DUT's own types.
   Included into the testbench top; the first mismatch ends the run. */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////////////////////////
// Failure exit
////////////////////////////////////////

task automatic stop_with_failure(input string what);
  $display("%s", what);
  $display("Simulation finished: FAIL");
  $fatal(1);
endtask

////////////////////////////////////////
// Typed compares
////////////////////////////////////////

// Tagged output word, src and payload together
task automatic compare_merged(input string name, input stream_pkg::merged_t expected,
                              input stream_pkg::merged_t actual);
  if (actual !== expected) begin
    stop_with_failure($sformatf("Fail %s: expected %0h, actual %0h",
                                name, expected, actual));
  end
endtask

// Fill levels and word counts
task automatic compare_level(input string name, input cdc_pkg::fill_level_t expected,
                             input cdc_pkg::fill_level_t actual);
  if (actual !== expected) begin
    stop_with_failure($sformatf("Fail %s: expected %0d, actual %0d",
                                name, expected, actual));
  end
endtask

// Single status bits
task automatic compare_flag(input string name, input logic expected, input logic actual);
  if (actual !== expected) begin
    stop_with_failure($sformatf("Fail %s: expected %0b, actual %0b",
                                name, expected, actual));
  end
endtask

// Source tag of a merged word
task automatic compare_src(input string name, input stream_pkg::src_e expected,
                           input stream_pkg::src_e actual);
  if (actual !== expected) begin
    stop_with_failure($sformatf("Fail %s: expected %s, actual %s",
                                name, expected.name(), actual.name()));
  end
endtask

`endif

// File: testbench/tb_cdc_merge.sv
/* Testbench for the two-channel crossing merger. Random traffic is checked
   against per-channel reference queues, then round-robin, full and drain tests. */
`include "cdc_macros.svh"

module tb_cdc_merge;

  // Test lengths in clk_rp cycles
  localparam int LEN_RESET       = 20;
  localparam int LEN_RANDOM      = 500;
  localparam int LEN_ROUND_ROBIN = 80;
  localparam int LEN_FILL        = 150;
  localparam int LEN_DRAIN       = 60;
  localparam int TIMEOUT_CYCLES  =
    4 * (2 * LEN_RESET + LEN_RANDOM + LEN_ROUND_ROBIN + LEN_FILL + LEN_DRAIN);

  localparam int RANDOM_WR_CYCLES = 300;
  localparam int RANDOM_RD_CYCLES = 390;
  // More samples than commands so samples finish the round-robin run
  localparam int RR_SAMPLES = 12;
  localparam int RR_CMDS    = 7;
  localparam int CORE_DEPTH  = 1 << `CDC_CORE_AW;
  localparam int TOTAL_DEPTH = CORE_DEPTH + (1 << `CDC_PREFETCH_AW);

  logic                clk_rp = 1'b0;
  logic                clk_wp = 1'b0;
  logic                rst_rp_n;
  logic                rst_wp_n;
  logic                sample_write_en;
  stream_pkg::sample_t sample_data;
  logic                sample_full;
  logic                cmd_write_en;
  stream_pkg::cmd_t    cmd_data;
  logic                cmd_full;
  logic                read_en;
  stream_pkg::merged_t out_data;
  logic                out_valid;
  logic                empty;
  cdc_pkg::wr_status_t sample_wr_status;
  cdc_pkg::wr_status_t cmd_wr_status;
  cdc_pkg::rd_status_t sample_rd_status;
  cdc_pkg::rd_status_t cmd_rd_status;

  // Reference model of expected output words per channel in write order
  stream_pkg::merged_t sample_q[$];
  stream_pkg::merged_t cmd_q[$];
  stream_pkg::src_e    src_log[$];

  logic [15:0] lfsr_state  = 16'd14;
  // Accepted read strobes one and two clk_rp cycles back
  logic        acc_d1;
  logic        acc_d2;
  int unsigned cycle_count = 0;

  `include "tb_checks.svh"

  cdc_merge_top uut (.*);

  always #10 clk_rp = ~clk_rp;
  // Write clock unrelated to the read clock
  always #13 clk_wp = ~clk_wp;

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits       = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return bits;
  endfunction

  // Sample fills the whole payload
  function automatic stream_pkg::merged_t sample_word(input stream_pkg::sample_t s);
    stream_pkg::merged_t m;
    m.src     = stream_pkg::SRC_SAMPLE;
    m.payload = {s.data, s.lr};
    return m;
  endfunction

  // Command right-aligned with zeros above
  function automatic stream_pkg::merged_t cmd_word(input stream_pkg::cmd_t c);
    stream_pkg::merged_t m;
    m.src     = stream_pkg::SRC_CMD;
    m.payload = '0;
    m.payload[`CDC_CMD_OP_W+`CDC_CMD_ARG_W-1:0] = {c.opcode, c.arg};
    return m;
  endfunction

  ////////////////////////////////////////
  // Monitors and timeout
  ////////////////////////////////////////

  // Accepted writes sampled on the edge the DUT uses
  always @(posedge clk_wp) begin
    if (rst_wp_n) begin
      if (sample_write_en && !sample_full) begin
        sample_q.push_back(sample_word(sample_data));
      end
      if (cmd_write_en && !cmd_full) begin
        cmd_q.push_back(cmd_word(cmd_data));
      end
    end
  end

  // out_valid must trail an accepted read_en by exactly two cycles
  always @(posedge clk_rp) begin
    if (!rst_rp_n) begin
      acc_d1 = 1'b0;
      acc_d2 = 1'b0;
    end else begin
      compare_flag("out_valid two cycles after read_en", acc_d2, out_valid);
      if (out_valid) begin
        src_log.push_back(out_data.src);
        if (out_data.src == stream_pkg::SRC_SAMPLE && sample_q.size() == 0) begin
          stop_with_failure("A sample word came out that was never written");
        end else if (out_data.src == stream_pkg::SRC_CMD && cmd_q.size() == 0) begin
          stop_with_failure("A command word came out that was never written");
        end else if (out_data.src == stream_pkg::SRC_SAMPLE) begin
          compare_merged("sample word", sample_q.pop_front(), out_data);
        end else begin
          compare_merged("command word", cmd_q.pop_front(), out_data);
        end
      end
      acc_d2 = acc_d1;
      acc_d1 = read_en && !empty;
    end
  end

  always @(posedge clk_rp) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      stop_with_failure("Timeout: the tests did not finish within the cycle limit");
    end
  end

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  // Both resets low together and each released after 10 of its own cycles
  task automatic apply_reset();
    @(posedge clk_rp);
    rst_rp_n <= 1'b0;
    rst_wp_n <= 1'b0;
    fork
      begin
        repeat (10) @(posedge clk_rp);
        rst_rp_n <= 1'b1;
      end
      begin
        repeat (10) @(posedge clk_wp);
        rst_wp_n <= 1'b1;
      end
    join
  endtask

  task automatic check_reset_state();
    @(negedge clk_rp);
    compare_flag("reset out_valid", 1'b0, out_valid);
    compare_flag("reset empty", 1'b1, empty);
    compare_flag("reset sample_full", 1'b0, sample_full);
    compare_flag("reset cmd_full", 1'b0, cmd_full);
    compare_level("reset sample wr level", '0, sample_wr_status.fill_level);
    compare_level("reset sample wr max", '0, sample_wr_status.max_fill_level);
    compare_level("reset cmd wr level", '0, cmd_wr_status.fill_level);
    compare_level("reset cmd wr max", '0, cmd_wr_status.max_fill_level);
    compare_level("reset sample rd level", '0, sample_rd_status.fill_level);
    compare_level("reset cmd rd level", '0, cmd_rd_status.fill_level);
  endtask

  task automatic drive_random_writes();
    logic [31:0] r;
    repeat (RANDOM_WR_CYCLES) begin
      @(posedge clk_wp);
      // Samples in about three cycles of four and commands in one of two
      r = take_bits(2);
      sample_write_en <= (r[1:0] != 2'b00);
      r = take_bits(25);
      sample_data <= r[24:0];
      r = take_bits(1);
      cmd_write_en <= r[0];
      r = take_bits(16);
      cmd_data <= r[15:0];
    end
    @(posedge clk_wp);
    sample_write_en <= 1'b0;
    cmd_write_en    <= 1'b0;
  endtask

  // Reads slower than writes so both FIFOs reach full
  task automatic drive_random_reads();
    logic [31:0] r;
    repeat (RANDOM_RD_CYCLES) begin
      @(posedge clk_rp);
      r = take_bits(1);
      read_en <= r[0];
    end
  endtask

  // Read until every written word has come out
  task automatic drain_all();
    @(posedge clk_rp);
    read_en <= 1'b1;
    do @(negedge clk_rp);
    while (!(empty && sample_q.size() == 0 && cmd_q.size() == 0));
    @(posedge clk_rp);
    read_en <= 1'b0;
  endtask

  task automatic check_round_robin();
    logic [31:0]      r;
    stream_pkg::src_e exp_src;
    // Preload both channels and then let every word cross
    for (int i = 0; i < RR_SAMPLES; i++) begin
      @(posedge clk_wp);
      r = take_bits(25);
      sample_write_en <= 1'b1;
      sample_data     <= r[24:0];
      r = take_bits(16);
      cmd_write_en <= (i < RR_CMDS);
      cmd_data     <= r[15:0];
    end
    @(posedge clk_wp);
    sample_write_en <= 1'b0;
    cmd_write_en    <= 1'b0;
    repeat (20) @(posedge clk_rp);
    src_log.delete();
    drain_all();
    compare_level("round robin words", cdc_pkg::fill_level_t'(RR_SAMPLES + RR_CMDS),
                  cdc_pkg::fill_level_t'(src_log.size()));
    // Alternate from samples and samples alone once commands run out
    for (int i = 0; i < src_log.size(); i++) begin
      if (i >= 2 * RR_CMDS || i % 2 == 0) begin
        exp_src = stream_pkg::SRC_SAMPLE;
      end else begin
        exp_src = stream_pkg::SRC_CMD;
      end
      compare_src($sformatf("round robin word %0d", i), exp_src, src_log[i]);
    end
  endtask

  // Writes held on until full is seen and three more that a full FIFO drops
  task automatic fill_until_full();
    logic [31:0] r;
    @(negedge clk_wp);
    while (!sample_full) begin
      @(posedge clk_wp);
      r = take_bits(25);
      sample_write_en <= 1'b1;
      sample_data     <= r[24:0];
      @(negedge clk_wp);
    end
    repeat (3) @(posedge clk_wp);
    sample_write_en <= 1'b0;
  endtask

  task automatic check_fill_to_full();
    fill_until_full();
    // Prefetch pulls free core space once the read pointer crosses back
    repeat (20) @(posedge clk_rp);
    fill_until_full();
    repeat (20) @(posedge clk_rp);
    @(negedge clk_wp);
    compare_level("accepted writes", cdc_pkg::fill_level_t'(TOTAL_DEPTH),
                  cdc_pkg::fill_level_t'(sample_q.size()));
    compare_flag("full held", 1'b1, sample_full);
    compare_level("write max level", cdc_pkg::fill_level_t'(CORE_DEPTH),
                  sample_wr_status.max_fill_level);
  endtask

  task automatic check_drain_levels();
    cdc_pkg::fill_level_t expected;
    logic                 was_empty;
    @(posedge clk_rp);
    read_en <= 1'b1;
    @(negedge clk_rp);
    expected = cdc_pkg::fill_level_t'(TOTAL_DEPTH);
    compare_level("drain start level", expected, sample_rd_status.fill_level);
    // One word less for each accepted read
    while (expected != 0) begin
      was_empty = empty;
      @(negedge clk_rp);
      if (!was_empty) begin
        expected = expected - 1'b1;
      end
      compare_level("drain level", expected, sample_rd_status.fill_level);
    end
    @(posedge clk_rp);
    read_en <= 1'b0;
    // A strobe while empty must give no word
    @(posedge clk_rp);
    read_en <= 1'b1;
    @(posedge clk_rp);
    read_en <= 1'b0;
    repeat (3) begin
      @(negedge clk_rp);
      compare_flag("out_valid after empty read", 1'b0, out_valid);
    end
    compare_flag("empty after drain", 1'b1, empty);
    compare_level("cmd rd level after drain", '0, cmd_rd_status.fill_level);
    compare_level("sample queue left", '0, cdc_pkg::fill_level_t'(sample_q.size()));
  endtask

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////

  initial begin
    rst_rp_n        <= 1'b0;
    rst_wp_n        <= 1'b0;
    sample_write_en <= 1'b0;
    sample_data     <= '0;
    cmd_write_en    <= 1'b0;
    cmd_data        <= '0;
    read_en         <= 1'b0;
    apply_reset();
    check_reset_state();
    fork
      drive_random_writes();
      drive_random_reads();
    join
    drain_all();
    // Fresh reset so the merger serves samples first
    apply_reset();
    check_round_robin();
    check_fill_to_full();
    check_drain_levels();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: tb.f
+incdir+rtl
+incdir+testbench
rtl/cdc_pkg.sv
rtl/stream_pkg.sv
rtl/gray_sync.sv
rtl/afifo_core.sv
rtl/prefetch_fifo.sv
rtl/afifo.sv
rtl/stream_merge.sv
rtl/cdc_merge_top.sv
testbench/tb_cdc_merge.sv
